/* hw/fpDivSqrtPkg.sv */
// ***********************************************************
// single precision normal operands only, truncating results
// no zero, denormal, inf, NaN or exponent range handling
// ***********************************************************
`default_nettype none

package fpDivSqrtPkg;

  // opcode encoding
  localparam logic opDiv = 1'b0;
  localparam logic opSqrt = 1'b1;

  localparam int TagWidth = 8;
  localparam int MantWidth = 24;  // hidden bit included
  localparam int IterSteps = 24;  // one result bit per step, both ops
  localparam int ExpBias = 127;

  // one operand word, raw or split into IEEE fields
  typedef union packed {
    logic [31:0] bits;
    struct packed {
      logic sign;
      logic [7:0] exponent;
      logic [22:0] fraction;
    } fields;
  } fpWord;

endpackage

`default_nettype wire

/* hw/fpDivSqrtUnit.sv */
// ***********************************************************
// results may return out of order, match them by outTag
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module fpDivSqrtUnit #(
  parameter int QueueDepth = 4,
  parameter int NumEngines = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  logic inOp,
  input  fpDivSqrtPkg::fpWord inA,
  input  fpDivSqrtPkg::fpWord inB,
  input  logic [fpDivSqrtPkg::TagWidth-1:0] inTag,
  output logic full,
  output logic outValid,
  output logic [fpDivSqrtPkg::TagWidth-1:0] outTag,
  output fpDivSqrtPkg::fpWord outResult
);

  localparam int MW = fpDivSqrtPkg::MantWidth;
  localparam int TW = fpDivSqrtPkg::TagWidth;

  logic issueValid, issueOp;
  logic [NumEngines-1:0] issueSel, startVec, busy, done, grant, resSign;
  fpDivSqrtPkg::fpWord issueA, issueB;
  logic [TW-1:0] issueTag, uTag;
  logic uOp, uSign;
  logic [47:0] uNum;
  logic [MW-1:0] uDen;
  logic signed [9:0] uExp;
  logic [NumEngines*MW-1:0] resMant;
  logic [NumEngines*8-1:0] resExp;
  logic [NumEngines*TW-1:0] resTag;

  issueQueue #(.QueueDepth(QueueDepth), .NumEngines(NumEngines)) queue (
    .clk, .rst, .inValid, .inOp, .inA, .inB, .inTag, .busy,
    .full, .issueValid, .issueSel, .issueOp, .issueA, .issueB, .issueTag
  );

  operandUnpack #(.NumEngines(NumEngines)) unpack (
    .clk, .rst, .issueValid, .issueSel, .issueOp, .issueA, .issueB, .issueTag,
    .startVec, .uOp, .uNum, .uDen, .uSign, .uExp, .uTag
  );

  for (genvar e = 0; e < NumEngines; e++) begin : engine
    iterEngine core (
      .clk, .rst, .start(startVec[e]), .uOp, .uNum, .uDen, .uSign, .uExp, .uTag,
      .grant(grant[e]), .busy(busy[e]), .done(done[e]),
      .resMant(resMant[e*MW +: MW]), .resSign(resSign[e]),
      .resExp(resExp[e*8 +: 8]), .resTag(resTag[e*TW +: TW])
    );
  end

  resultArbiter #(.NumEngines(NumEngines)) arbiter (
    .clk, .rst, .done, .resMant, .resSign, .resExp, .resTag,
    .grant, .outValid, .outTag, .outResult
  );

endmodule

`default_nettype wire

/* hw/issueQueue.sv */
// ***********************************************************
// inValid must stay low while full is high, no overflow check
// head issues to the lowest idle engine, one per cycle
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module issueQueue #(
  parameter int QueueDepth = 4,
  parameter int NumEngines = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  logic inOp,
  input  fpDivSqrtPkg::fpWord inA,
  input  fpDivSqrtPkg::fpWord inB,
  input  logic [fpDivSqrtPkg::TagWidth-1:0] inTag,
  input  logic [NumEngines-1:0] busy,
  output logic full,
  output logic issueValid,
  output logic [NumEngines-1:0] issueSel,
  output logic issueOp,
  output fpDivSqrtPkg::fpWord issueA,
  output fpDivSqrtPkg::fpWord issueB,
  output logic [fpDivSqrtPkg::TagWidth-1:0] issueTag
);

  localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CntWidth = $clog2(QueueDepth + 1);

  logic opMem [QueueDepth];
  logic [31:0] aMem [QueueDepth];
  logic [31:0] bMem [QueueDepth];
  logic [fpDivSqrtPkg::TagWidth-1:0] tagMem [QueueDepth];

  logic [PtrWidth-1:0] rdPtr, wrPtr;
  logic [CntWidth-1:0] count;
  logic [NumEngines-1:0] lastSel;  // start still sitting in the unpack stage
  logic [NumEngines-1:0] idle, pick;

  assign idle = ~busy & ~lastSel;

  always_comb begin
    pick = '0;
    for (int i = NumEngines - 1; i >= 0; i--) begin
      if (idle[i]) begin
        pick = '0;
        pick[i] = 1'b1;
      end
    end
  end

  assign full = (count == CntWidth'(QueueDepth));
  assign issueValid = (count != '0) && (|idle);
  assign issueSel = issueValid ? pick : '0;
  assign issueOp = opMem[rdPtr];
  assign issueA.bits = aMem[rdPtr];
  assign issueB.bits = bMem[rdPtr];
  assign issueTag = tagMem[rdPtr];

  always_ff @(posedge clk) begin
    if (inValid) begin
      opMem[wrPtr] <= inOp;
      aMem[wrPtr] <= inA.bits;
      bMem[wrPtr] <= inB.bits;
      tagMem[wrPtr] <= inTag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
      lastSel <= '0;
    end else begin
      lastSel <= issueSel;
      if (inValid)
        wrPtr <= (wrPtr == PtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (issueValid)
        rdPtr <= (rdPtr == PtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
      count <= count + CntWidth'(inValid) - CntWidth'(issueValid);
    end
  end

endmodule

`default_nettype wire

/* hw/iterEngine.sv */
// ***********************************************************
// radix-2 divide or square root, IterSteps cycles start to done
// result held until granted, start only while idle
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module iterEngine (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic uOp,
  input  logic [47:0] uNum,
  input  logic [fpDivSqrtPkg::MantWidth-1:0] uDen,
  input  logic uSign,
  input  logic signed [9:0] uExp,
  input  logic [fpDivSqrtPkg::TagWidth-1:0] uTag,
  input  logic grant,
  output logic busy,
  output logic done,
  output logic [fpDivSqrtPkg::MantWidth-1:0] resMant,
  output logic resSign,
  output logic [7:0] resExp,
  output logic [fpDivSqrtPkg::TagWidth-1:0] resTag
);

  localparam int CntWidth = $clog2(fpDivSqrtPkg::IterSteps + 1);

  logic [CntWidth-1:0] stepCnt;
  logic opReg;
  logic [fpDivSqrtPkg::MantWidth-1:0] denReg;
  logic [25:0] rem;
  logic [47:0] pend;  // numerator bits not yet consumed
  logic [fpDivSqrtPkg::MantWidth-1:0] acc;  // quotient or root so far

  logic stepping, curOp, ge;
  logic [fpDivSqrtPkg::MantWidth-1:0] curDen, curAcc;
  logic [25:0] curRem;
  logic [47:0] curPend;
  logic [27:0] wide, trial, diff;

  assign stepping = start | (busy & ~done);

  // first step runs on the start edge straight from the bus
  always_comb begin
    curOp = start ? uOp : opReg;
    curDen = start ? uDen : denReg;
    curAcc = start ? '0 : acc;
    if (start) begin
      curRem = (uOp == fpDivSqrtPkg::opDiv) ? {2'b00, uNum[47:24]} : '0;
      curPend = (uOp == fpDivSqrtPkg::opDiv) ? {uNum[23:0], 24'b0} : uNum;
    end else begin
      curRem = rem;
      curPend = pend;
    end
    if (curOp == fpDivSqrtPkg::opDiv) begin
      wide = {2'b00, curRem[24:0], curPend[47]};
      trial = {4'b0000, curDen};
    end else begin
      wide = {curRem, curPend[47:46]};
      trial = {2'b00, curAcc, 2'b01};
    end
    ge = (wide >= trial);
    diff = wide - trial;
  end

  always_ff @(posedge clk) begin
    if (stepping) begin
      rem <= ge ? diff[25:0] : wide[25:0];
      pend <= (curOp == fpDivSqrtPkg::opDiv) ? curPend << 1 : curPend << 2;
      acc <= {curAcc[fpDivSqrtPkg::MantWidth-2:0], ge};
    end
    if (start) begin
      opReg <= uOp;
      denReg <= uDen;
      resSign <= uSign;
      resExp <= uExp[7:0];
      resTag <= uTag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      stepCnt <= '0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
      stepCnt <= CntWidth'(1);
    end else if (busy && !done) begin
      stepCnt <= stepCnt + 1'b1;
      if (stepCnt == CntWidth'(fpDivSqrtPkg::IterSteps - 1))
        done <= 1'b1;
    end else if (done && grant) begin
      busy <= 1'b0;
      done <= 1'b0;
    end
  end

  assign resMant = acc;

endmodule

`default_nettype wire

/* hw/operandUnpack.sv */
// ***********************************************************
// one cycle stage, operands assumed normal and in range
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module operandUnpack #(
  parameter int NumEngines = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic issueValid,
  input  logic [NumEngines-1:0] issueSel,
  input  logic issueOp,
  input  fpDivSqrtPkg::fpWord issueA,
  input  fpDivSqrtPkg::fpWord issueB,
  input  logic [fpDivSqrtPkg::TagWidth-1:0] issueTag,
  output logic [NumEngines-1:0] startVec,
  output logic uOp,
  output logic [47:0] uNum,
  output logic [fpDivSqrtPkg::MantWidth-1:0] uDen,
  output logic uSign,
  output logic signed [9:0] uExp,
  output logic [fpDivSqrtPkg::TagWidth-1:0] uTag
);

  localparam logic signed [9:0] Bias = 10'(fpDivSqrtPkg::ExpBias);

  logic [fpDivSqrtPkg::MantWidth-1:0] mA, mB;
  logic signed [9:0] eA, eB, eU, halfExp, nextExp;
  logic [24:0] base;  // dividend or radicand, maybe doubled
  logic nextSign;

  always_comb begin
    mA = {1'b1, issueA.fields.fraction};
    mB = {1'b1, issueB.fields.fraction};
    eA = {2'b00, issueA.fields.exponent};
    eB = {2'b00, issueB.fields.exponent};
    eU = eA - Bias;
    halfExp = '0;
    if (issueOp == fpDivSqrtPkg::opSqrt) begin
      if (eU[0]) begin  // odd exponent
        base = {mA, 1'b0};
        eU = eU - 10'sd1;
      end else begin
        base = {1'b0, mA};
      end
      halfExp = eU >>> 1;
      nextExp = halfExp + Bias;
      nextSign = 1'b0;
    end else begin
      if (mA < mB) begin
        base = {mA, 1'b0};
        nextExp = eA - eB + Bias - 10'sd1;
      end else begin
        base = {1'b0, mA};
        nextExp = eA - eB + Bias;
      end
      nextSign = issueA.fields.sign ^ issueB.fields.sign;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      startVec <= '0;
    else
      startVec <= issueValid ? issueSel : '0;
  end

  always_ff @(posedge clk) begin
    if (issueValid) begin
      uOp <= issueOp;
      uNum <= {base, 23'b0};
      uDen <= mB;
      uSign <= nextSign;
      uExp <= nextExp;
      uTag <= issueTag;
    end
  end

endmodule

`default_nettype wire

/* hw/resultArbiter.sv */
// ***********************************************************
// fixed priority, engine 0 wins, no output back-pressure
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module resultArbiter #(
  parameter int NumEngines = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic [NumEngines-1:0] done,
  input  logic [NumEngines*fpDivSqrtPkg::MantWidth-1:0] resMant,
  input  logic [NumEngines-1:0] resSign,
  input  logic [NumEngines*8-1:0] resExp,
  input  logic [NumEngines*fpDivSqrtPkg::TagWidth-1:0] resTag,
  output logic [NumEngines-1:0] grant,
  output logic outValid,
  output logic [fpDivSqrtPkg::TagWidth-1:0] outTag,
  output fpDivSqrtPkg::fpWord outResult
);

  logic [fpDivSqrtPkg::MantWidth-1:0] selMant;
  logic [7:0] selExp;
  logic [fpDivSqrtPkg::TagWidth-1:0] selTag;
  logic selSign;

  // downward scan, so the lowest done index is kept last
  always_comb begin
    grant = '0;
    selMant = '0;
    selExp = '0;
    selTag = '0;
    selSign = 1'b0;
    for (int i = NumEngines - 1; i >= 0; i--) begin
      if (done[i]) begin
        grant = '0;
        grant[i] = 1'b1;
        selMant = resMant[i*fpDivSqrtPkg::MantWidth +: fpDivSqrtPkg::MantWidth];
        selExp = resExp[i*8 +: 8];
        selTag = resTag[i*fpDivSqrtPkg::TagWidth +: fpDivSqrtPkg::TagWidth];
        selSign = resSign[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |done;
  end

  always_ff @(posedge clk) begin
    if (|done) begin
      outTag <= selTag;
      outResult.fields.sign <= selSign;
      outResult.fields.exponent <= selExp;
      outResult.fields.fraction <= selMant[fpDivSqrtPkg::MantWidth-2:0];  // drop hidden bit
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module fpDivSqrtTb --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/simv 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi

/* src.f */
hw/fpDivSqrtPkg.sv
hw/issueQueue.sv
hw/operandUnpack.sv
hw/iterEngine.sv
hw/resultArbiter.sv
hw/fpDivSqrtUnit.sv
test/fpDivSqrt_chk.sv
test/fpDivSqrtTb.sv

/* test/fpDivSqrtTb.sv */
// ***********************************************************
// random normal operands only
// tags are unique per run and stay below 256
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module fpDivSqrtTb;

  localparam int NumEngines = 3;
  localparam int NumDiv = 8;
  localparam int NumSqrt = 8;
  localparam int NumMixed = 30;
  localparam int NumFill = 60;
  localparam int NumReq = NumDiv + NumSqrt + NumMixed + NumFill;
  localparam int WatchCycles = NumReq * (fpDivSqrtPkg::IterSteps + 8) + 200;

  logic clk, rst, inValid, inOp, full, outValid;
  fpDivSqrtPkg::fpWord inA, inB, outResult;
  logic [fpDivSqrtPkg::TagWidth-1:0] inTag, outTag;

  logic [31:0] lcgState = 32'd4;
  logic [31:0] expected [256];
  logic pending [256];
  int sent, received, maxBusy;
  logic sawFull;

  fpDivSqrtUnit #(.QueueDepth(4), .NumEngines(NumEngines)) dut (
    .clk(clk), .rst(rst), .inValid(inValid), .inOp(inOp), .inA(inA), .inB(inB),
    .inTag(inTag), .full(full), .outValid(outValid), .outTag(outTag),
    .outResult(outResult)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // exponent kept in 64..190
  function automatic logic [31:0] randOperand(input logic withSign);
    logic [31:0] r;
    logic [7:0] exponent;
    r = nextRand();
    exponent = 8'(64 + ((nextRand() >> 8) % 127));
    return {withSign & r[31], exponent, r[30:8]};
  endfunction

  function automatic logic [31:0] modelDiv(input logic [31:0] a, input logic [31:0] b);
    fpDivSqrtPkg::fpWord wa, wb;
    logic [23:0] mA, mB;
    logic [47:0] num, q;
    int e;
    wa.bits = a;
    wb.bits = b;
    mA = {1'b1, wa.fields.fraction};
    mB = {1'b1, wb.fields.fraction};
    e = int'(wa.fields.exponent) - int'(wb.fields.exponent) + fpDivSqrtPkg::ExpBias;
    if (mA < mB) begin
      num = {mA, 24'b0};  // doubled dividend keeps the quotient in [1,2)
      e = e - 1;
    end else begin
      num = {1'b0, mA, 23'b0};
    end
    q = num / {24'b0, mB};
    return {wa.fields.sign ^ wb.fields.sign, 8'(e), q[22:0]};
  endfunction

  // greedy bit search for floor(sqrt)
  function automatic logic [31:0] modelSqrt(input logic [31:0] a);
    fpDivSqrtPkg::fpWord wa;
    logic [23:0] mA, root, trial;
    logic [47:0] rad, sq;
    int e;
    wa.bits = a;
    mA = {1'b1, wa.fields.fraction};
    e = int'(wa.fields.exponent) - fpDivSqrtPkg::ExpBias;
    rad = {1'b0, mA, 23'b0};
    if (e % 2 != 0) begin
      rad = {mA, 24'b0};
      e = e - 1;
    end
    root = '0;
    for (int k = 23; k >= 0; k--) begin
      trial = root | (24'd1 << k);
      sq = {24'b0, trial} * {24'b0, trial};
      if (sq <= rad)
        root = trial;
    end
    return {1'b0, 8'(e / 2 + fpDivSqrtPkg::ExpBias), root[22:0]};
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  // starts on a falling edge and returns on the next one
  task automatic driveOne(input logic op, input logic [31:0] a, input logic [31:0] b);
    inValid = 1'b1;
    inOp = op;
    inA.bits = a;
    inB.bits = b;
    inTag = 8'(sent);
    expected[sent] = (op == fpDivSqrtPkg::opSqrt) ? modelSqrt(a) : modelDiv(a, b);
    pending[sent] = 1'b1;
    sent++;
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic waitDrain();
    while (received != sent)
      @(posedge clk);
    @(negedge clk);
  endtask

  // outputs are registered so the falling edge sees them settled
  always @(negedge clk) begin
    if (!rst) begin
      if (full)
        sawFull = 1'b1;
      if ($countones(dut.busy) > maxBusy)
        maxBusy = $countones(dut.busy);
      if (outValid) begin
        assert (pending[outTag])
          else failRun($sformatf("result for tag %0d came back with no request pending",
                                 outTag));
        assert (outResult.bits == expected[outTag])
          else failRun($sformatf("MISMATCH outResult: got 0x%h, expected 0x%h (tag 0x%h)",
                                 outResult.bits, expected[outTag], outTag));
        pending[outTag] = 1'b0;
        received++;
      end
    end
  end

  initial begin
    repeat (WatchCycles) @(posedge clk);
    failRun($sformatf("watchdog expired with results still outstanding, %0d of %0d returned",
                      received, sent));
  end

  initial begin
    logic [31:0] a, b, r;
    logic [22:0] fa, fb;
    logic op;
    rst = 1'b1;
    inValid = 1'b0;
    inOp = 1'b0;
    inA = '0;
    inB = '0;
    inTag = '0;
    sent = 0;
    received = 0;
    maxBusy = 0;
    sawFull = 1'b0;
    for (int t = 0; t < 256; t++) begin
      pending[t] = 1'b0;
      expected[t] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    repeat (4) begin
      assert (!outValid && !full)
        else failRun("outValid or full went high before any request was sent");
      @(negedge clk);
    end

    // even i forces mA < mB
    for (int i = 0; i < NumDiv; i++) begin
      a = randOperand(1'b1);
      b = randOperand(1'b1);
      fa = a[22:0];
      fb = b[22:0];
      if ((i % 2 == 0) != (fa < fb)) begin
        a[22:0] = fb;
        b[22:0] = fa;
      end
      driveOne(fpDivSqrtPkg::opDiv, a, b);
      waitDrain();
      repeat (2) @(negedge clk);
    end

    for (int i = 0; i < NumSqrt; i++) begin
      a = randOperand(1'b0);
      b = randOperand(1'b0);
      // odd i gets an odd unbiased exponent
      a[30:23] = 8'(64 + 2 * ((nextRand() >> 8) % 63) + ((i % 2 == 0) ? 1 : 0));
      driveOne(fpDivSqrtPkg::opSqrt, a, b);
      waitDrain();
      repeat (2) @(negedge clk);
    end

    for (int i = 0; i < NumMixed; i++) begin
      while (full)
        @(negedge clk);
      r = nextRand();
      op = r[20];
      a = randOperand(!op);
      b = randOperand(!op);
      driveOne(op, a, b);
    end
    waitDrain();
    assert (maxBusy == NumEngines)
      else failRun("the engines never all ran at the same time during the mixed burst");

    sawFull = 1'b0;
    for (int i = 0; i < NumFill; i++) begin
      while (full)
        @(negedge clk);
      r = nextRand();
      op = r[17];
      a = randOperand(!op);
      b = randOperand(!op);
      driveOne(op, a, b);
    end
    waitDrain();
    assert (sawFull)
      else failRun("full never rose during the sustained burst");

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* test/fpDivSqrt_chk.sv */
// ***********************************************************
// protocol checks bound into the unit
// NumEngines comes from the bound target
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module fpDivSqrtChk #(
  parameter int NumEngines = 3
) (
  input logic clk,
  input logic rst,
  input logic inValid,
  input logic full,
  input logic outValid,
  input logic [NumEngines-1:0] grant,
  input logic [NumEngines-1:0] done
);

  // one edge into reset the output register is cleared
  resetQuiet: assert property (@(posedge clk) $past(rst) |-> !outValid)
    else $error("outValid high while in reset");

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant has more than one bit set");

  // a granted engine has finished and drops done one cycle later
  grantDone: assert property (@(posedge clk) disable iff (rst)
      ((grant & ~done) == '0) && (($past(grant) & done) == '0))
    else $error("grant does not match the finished engines");

  noPushWhenFull: assert property (@(posedge clk) disable iff (rst) !(inValid && full))
    else $error("request pushed while the queue is full");

endmodule

bind fpDivSqrtUnit fpDivSqrtChk #(.NumEngines(NumEngines)) chk (
  .clk(clk), .rst(rst), .inValid(inValid), .full(full), .outValid(outValid),
  .grant(grant), .done(done)
);

`default_nettype wire
